//--- include/eth_crc32.svh
`ifndef ETH_CRC32_SVH
`define ETH_CRC32_SVH

// ------------------------------
// ethernet crc32, reflected form
// ------------------------------

// reversed form of 0x04C11DB7
localparam logic [31:0] CRC_POLY   = 32'hEDB8_8320;
localparam logic [31:0] CRC_PRESET = 32'hFFFF_FFFF;

// advance the crc by one byte, lsb first as on the wire
function automatic logic [31:0] CRC_STEP_BYTE(
    input logic [31:0] crc,
    input logic [7:0]  data
);
    logic [31:0] c;
    c = crc ^ {24'h0, data};
    for (int i = 0; i < 8; i++) begin
        if (c[0]) begin
            c = (c >> 1) ^ CRC_POLY;
        end else begin
            c = c >> 1;
        end
    end
    return c;
endfunction

`endif

//--- hw/xgmii_rx_pkg.sv
package xgmii_rx_pkg;

    // ------------------------------
    // xgmii characters
    // ------------------------------
    localparam logic [7:0] XGMII_START = 8'hFB;
    localparam logic [7:0] XGMII_TERM  = 8'hFD;
    localparam logic [7:0] XGMII_IDLE  = 8'h07;

    localparam int DATA_W = 64;
    localparam int LANES  = 8;

    // one xgmii word, lane 0 in the low byte
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [LANES-1:0]  ctrl;
    } xgmii_word_t;

    // payload beat from parser to crc checker
    typedef struct packed {
        logic [DATA_W-1:0] tdata;
        logic [LANES-1:0]  tkeep;
        logic              tvalid;
        logic              tlast;
    } rx_beat_t;

    // output stream, tuser is crc good on the last beat
    typedef struct packed {
        logic [DATA_W-1:0] tdata;
        logic [LANES-1:0]  tkeep;
        logic              tvalid;
        logic              tlast;
        logic              tuser;
    } rx_stream_t;

    // frame length in bytes, fcs included
    typedef logic [13:0] frame_len_t;

    typedef enum logic [3:0] {
        RUNT,
        FRAGMENT,
        SZ_64,
        SZ_65_127,
        SZ_128_255,
        SZ_256_511,
        SZ_512_1023,
        SZ_1024_MAX,
        OVERSIZE,
        JABBER
    } size_class_t;

    typedef struct packed {
        logic        valid;
        logic        crc_ok;
        frame_len_t  len;
        size_class_t size;
    } rx_stat_t;

    `include "eth_crc32.svh"

endpackage

//--- hw/xgmii_frame_parser.sv
`timescale 1ns/100ps

module xgmii_frame_parser
    import xgmii_rx_pkg::*;
(
    input  logic        clk,
    input  logic        inv_aresetn,
    input  xgmii_word_t xgmii_i,
    output rx_beat_t    beat_o,
    output logic [31:0] fcs_o,
    output logic        term_ok_o,
    output logic        abort_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DATA,
        ST_TAIL
    } state_t;

    state_t              state_q;
    state_t              state_d;
    logic                held_vld_q;
    logic                held_vld_d;
    logic [DATA_W-1:0]   hold_q;
    logic [DATA_W-1:0]   hold_d;
    logic [LANES-1:0]    tail_keep_q;
    logic [LANES-1:0]    tail_keep_d;
    rx_beat_t            beat_d;
    logic                side_ld;

    logic                is_start;
    logic [2:0]          term_lane;
    logic [LANES-1:0]    upper_mask;
    logic                lane_is_term;
    logic                term_ok;
    logic [2*DATA_W-1:0] word_pair;
    logic [31:0]         fcs_d;

    // ------------------------------
    // word decode
    // ------------------------------
    assign is_start = (xgmii_i.ctrl == 8'h01) && (xgmii_i.data[7:0] == XGMII_START);

    // lowest control lane of the word
    always_comb begin
        term_lane = '0;
        for (int i = LANES - 1; i >= 0; i--) begin
            if (xgmii_i.ctrl[i]) begin
                term_lane = 3'(i);
            end
        end
    end

    // every lane above t must be control
    assign upper_mask   = 8'hFE << term_lane;
    assign lane_is_term = (xgmii_i.data[8*term_lane +: 8] == XGMII_TERM);
    assign term_ok      = lane_is_term && ((xgmii_i.ctrl & upper_mask) == upper_mask);

    // fcs is the 4 bytes before T, across held and current word
    assign word_pair = {xgmii_i.data, hold_q};
    assign fcs_d     = word_pair[8*term_lane + 32 +: 32];

    // ------------------------------
    // fsm next state and beat
    // ------------------------------
    always_comb begin
        state_d     = state_q;
        held_vld_d  = held_vld_q;
        hold_d      = hold_q;
        tail_keep_d = tail_keep_q;
        side_ld     = 1'b0;
        beat_d      = '{tdata: hold_q, tkeep: 8'hFF, tvalid: 1'b0, tlast: 1'b0};

        case (state_q)
            ST_IDLE: begin
                // lane 4 starts and stray words fall through here
                if (is_start) begin
                    state_d    = ST_DATA;
                    held_vld_d = 1'b0;
                end
            end

            ST_DATA: begin
                if (xgmii_i.ctrl == '0) begin
                    beat_d.tvalid = held_vld_q;
                    hold_d        = xgmii_i.data;
                    held_vld_d    = 1'b1;
                end else begin
                    side_ld    = 1'b1;
                    held_vld_d = 1'b0;
                    state_d    = ST_IDLE;
                    if (!term_ok) begin
                        // bad end, close out with the held word
                        beat_d.tvalid = held_vld_q;
                        beat_d.tlast  = 1'b1;
                    end else if (term_lane < 3'd4) begin
                        beat_d.tvalid = held_vld_q;
                        beat_d.tlast  = 1'b1;
                        beat_d.tkeep  = 8'hFF >> (3'd4 - term_lane);
                    end else if (term_lane == 3'd4) begin
                        beat_d.tvalid = held_vld_q;
                        beat_d.tlast  = 1'b1;
                    end else begin
                        // ending word still has payload, one more beat
                        beat_d.tvalid = held_vld_q;
                        hold_d        = xgmii_i.data;
                        tail_keep_d   = 8'hFF >> (4'd12 - {1'b0, term_lane});
                        state_d       = ST_TAIL;
                    end
                end
            end

            ST_TAIL: begin
                beat_d.tvalid = 1'b1;
                beat_d.tlast  = 1'b1;
                beat_d.tkeep  = tail_keep_q;
                held_vld_d    = 1'b0;
                state_d       = is_start ? ST_DATA : ST_IDLE;
            end

            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // ------------------------------
    // registers
    // ------------------------------
    always_ff @(posedge clk) begin
        hold_q      <= hold_d;
        tail_keep_q <= tail_keep_d;
        beat_o      <= beat_d;
        // side info held through the tail beat
        if (side_ld) begin
            fcs_o     <= fcs_d;
            term_ok_o <= term_ok;
            abort_o   <= !lane_is_term;
        end
        if (inv_aresetn) begin
            state_q       <= ST_IDLE;
            held_vld_q    <= 1'b0;
            beat_o.tvalid <= 1'b0;
        end else begin
            state_q    <= state_d;
            held_vld_q <= held_vld_d;
        end
    end

    a_last_keep: assert property (
        @(posedge clk) disable iff (inv_aresetn)
        beat_o.tvalid && beat_o.tlast |-> beat_o.tkeep != '0
    );

endmodule

//--- hw/xgmii_crc_check.sv
`timescale 1ns/100ps

module xgmii_crc_check
    import xgmii_rx_pkg::*;
(
    input  logic        clk,
    input  logic        inv_aresetn,
    input  rx_beat_t    beat_i,
    input  logic [31:0] fcs_i,
    input  logic        term_ok_i,
    input  logic        abort_i,
    output rx_stream_t  axis_o
);

    logic [31:0] crc_q;
    logic [31:0] crc_d;
    logic        crc_match;
    logic        frame_good;

    // ------------------------------
    // running crc
    // ------------------------------

    // kept bytes only, lane 0 first
    always_comb begin
        crc_d = crc_q;
        for (int i = 0; i < LANES; i++) begin
            if (beat_i.tkeep[i]) begin
                crc_d = CRC_STEP_BYTE(crc_d, beat_i.tdata[8*i +: 8]);
            end
        end
    end

    assign crc_match  = (~crc_d == fcs_i);
    assign frame_good = beat_i.tlast && crc_match && term_ok_i && !abort_i;

    always_ff @(posedge clk) begin
        if (inv_aresetn) begin
            crc_q <= CRC_PRESET;
        end else if (beat_i.tvalid) begin
            // restart for the next frame
            if (beat_i.tlast) begin
                crc_q <= CRC_PRESET;
            end else begin
                crc_q <= crc_d;
            end
        end
    end

    // ------------------------------
    // output stage
    // ------------------------------
    always_ff @(posedge clk) begin
        axis_o.tdata <= beat_i.tdata;
        axis_o.tkeep <= beat_i.tkeep;
        axis_o.tlast <= beat_i.tlast;
        axis_o.tuser <= frame_good;
        if (inv_aresetn) begin
            axis_o.tvalid <= 1'b0;
        end else begin
            axis_o.tvalid <= beat_i.tvalid;
        end
    end

    // parser must hand over packed beats, full keep until the last
    a_keep_contig: assert property (
        @(posedge clk) disable iff (inv_aresetn)
        beat_i.tvalid |-> ((beat_i.tkeep & (beat_i.tkeep + 8'd1)) == '0)
            && (beat_i.tlast || beat_i.tkeep == 8'hFF)
    );

endmodule

//--- hw/rx_frame_stats.sv
`timescale 1ns/100ps

module rx_frame_stats
    import xgmii_rx_pkg::*;
#(
    parameter int MAX_FRAME_LEN = 1518
) (
    input  logic        clk,
    input  logic        inv_aresetn,
    input  rx_stream_t  axis_i,
    output rx_stat_t    stat_o,
    output logic [31:0] good_frames_o,
    output logic [31:0] bad_frames_o
);

    frame_len_t len_q;
    frame_len_t len_sum;
    frame_len_t frame_len;
    logic [3:0] beat_bytes;
    logic       frame_end;

    // size bins, short and long frames split by crc result
    function automatic size_class_t classify(input frame_len_t len, input logic crc_ok);
        if (len < 14'd64) begin
            return crc_ok ? RUNT : FRAGMENT;
        end else if (len == 14'd64) begin
            return SZ_64;
        end else if (len < 14'd128) begin
            return SZ_65_127;
        end else if (len < 14'd256) begin
            return SZ_128_255;
        end else if (len < 14'd512) begin
            return SZ_256_511;
        end else if (len < 14'd1024) begin
            return SZ_512_1023;
        end else if (len <= frame_len_t'(MAX_FRAME_LEN)) begin
            return SZ_1024_MAX;
        end
        return crc_ok ? OVERSIZE : JABBER;
    endfunction

    always_comb begin
        beat_bytes = '0;
        for (int i = 0; i < LANES; i++) begin
            beat_bytes = beat_bytes + 4'(axis_i.tkeep[i]);
        end
    end

    assign len_sum   = len_q + frame_len_t'(beat_bytes);
    // fcs bytes are stripped upstream, add them back
    assign frame_len = len_sum + 14'd4;
    assign frame_end = axis_i.tvalid && axis_i.tlast;

    always_ff @(posedge clk) begin
        if (frame_end) begin
            stat_o.crc_ok <= axis_i.tuser;
            stat_o.len    <= frame_len;
            stat_o.size   <= classify(frame_len, axis_i.tuser);
        end
        if (inv_aresetn) begin
            len_q         <= '0;
            stat_o.valid  <= 1'b0;
            good_frames_o <= '0;
            bad_frames_o  <= '0;
        end else begin
            stat_o.valid <= frame_end;
            if (axis_i.tvalid) begin
                len_q <= axis_i.tlast ? '0 : len_sum;
            end
            if (frame_end && axis_i.tuser) begin
                good_frames_o <= good_frames_o + 32'd1;
            end
            if (frame_end && !axis_i.tuser) begin
                bad_frames_o <= bad_frames_o + 32'd1;
            end
        end
    end

    a_stat_after_last: assert property (
        @(posedge clk) disable iff (inv_aresetn)
        stat_o.valid |-> $past(axis_i.tvalid && axis_i.tlast)
    );

endmodule

//--- hw/xgmii_rx_top.sv
`timescale 1ns/100ps

module xgmii_rx_top
    import xgmii_rx_pkg::*;
#(
    parameter int MAX_FRAME_LEN = 1518
) (
    input  logic        clk,
    input  logic        inv_aresetn,
    input  xgmii_word_t xgmii_i,
    output rx_stream_t  axis_o,
    output rx_stat_t    stat_o,
    output logic [31:0] good_frames_o,
    output logic [31:0] bad_frames_o
);

    // parser to checker
    rx_beat_t    beat;
    logic [31:0] fcs;
    logic        term_ok;
    logic        abort;

    xgmii_frame_parser u_parser (
        .clk         (clk),
        .inv_aresetn (inv_aresetn),
        .xgmii_i     (xgmii_i),
        .beat_o      (beat),
        .fcs_o       (fcs),
        .term_ok_o   (term_ok),
        .abort_o     (abort)
    );

    xgmii_crc_check u_crc_check (
        .clk         (clk),
        .inv_aresetn (inv_aresetn),
        .beat_i      (beat),
        .fcs_i       (fcs),
        .term_ok_i   (term_ok),
        .abort_i     (abort),
        .axis_o      (axis_o)
    );

    rx_frame_stats #(
        .MAX_FRAME_LEN (MAX_FRAME_LEN)
    ) u_stats (
        .clk           (clk),
        .inv_aresetn   (inv_aresetn),
        .axis_i        (axis_o),
        .stat_o        (stat_o),
        .good_frames_o (good_frames_o),
        .bad_frames_o  (bad_frames_o)
    );

endmodule

//--- verification/tb_eth_model.svh
`ifndef TB_ETH_MODEL_SVH
`define TB_ETH_MODEL_SVH

// ------------------------------
// stimulus source
// ------------------------------
logic [31:0] lfsr_state = 32'hdf6aad45;

// galois lfsr, one step per bit
function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_bit()};
    end
    return v;
endfunction

function automatic byte_q_t random_payload(input int len);
    byte_q_t p;
    for (int i = 0; i < len; i++) begin
        p.push_back(8'(rand_bits(8)));
    end
    return p;
endfunction

// ------------------------------
// reference fcs
// ------------------------------

// msb-first crc over wire bit order, mirrored into fcs byte order
function automatic logic [31:0] ref_fcs(input byte_q_t bytes);
    logic [31:0] crc;
    logic [31:0] fcs;
    logic        fb;
    crc = 32'hFFFF_FFFF;
    foreach (bytes[n]) begin
        for (int i = 0; i < 8; i++) begin
            fb  = crc[31] ^ bytes[n][i];
            crc = crc << 1;
            if (fb) begin
                crc = crc ^ 32'h04C1_1DB7;
            end
        end
    end
    for (int i = 0; i < 32; i++) begin
        fcs[i] = ~crc[31 - i];
    end
    return fcs;
endfunction

function automatic size_class_t expected_class(input int len, input logic ok);
    if (len < 64) begin
        return ok ? RUNT : FRAGMENT;
    end else if (len == 64) begin
        return SZ_64;
    end else if (len < 128) begin
        return SZ_65_127;
    end else if (len < 256) begin
        return SZ_128_255;
    end else if (len < 512) begin
        return SZ_256_511;
    end else if (len < 1024) begin
        return SZ_512_1023;
    end else if (len <= MAX_FRAME_LEN) begin
        return SZ_1024_MAX;
    end
    return ok ? OVERSIZE : JABBER;
endfunction

// ------------------------------
// xgmii driver
// ------------------------------
task automatic drive_word(input xgmii_word_t w);
    @(posedge clk);
    #1;
    xgmii = w;
endtask

task automatic send_idles(input int n);
    for (int i = 0; i < n; i++) begin
        drive_word(IDLE_WORD);
    end
endtask

// err_word below zero sends a clean frame
task automatic send_frame(input byte_q_t payload, input logic bad_fcs, input int err_word);
    byte_q_t     frame;
    logic [31:0] fcs;
    xgmii_word_t w;
    int          n;
    int          idx;
    int          got;
    int          t;
    int          k;
    logic        ok;
    frame = payload;
    fcs = ref_fcs(payload);
    if (bad_fcs) begin
        fcs[5] = ~fcs[5];
    end
    for (int i = 0; i < 4; i++) begin
        frame.push_back(fcs[8*i +: 8]);
    end
    n = frame.size();

    // expected output, from the frame rules
    if (err_word >= 0) begin
        got = 8 * err_word;
        k   = 8;
        ok  = 1'b0;
    end else begin
        got = payload.size();
        t   = n % 8;
        k   = (t > 4) ? t - 4 : t + 4;
        ok  = !bad_fcs;
    end
    for (int i = 0; i < got; i++) begin
        exp_bytes.push_back(frame[i]);
    end
    exp_nbytes.push_back(got);
    exp_keep.push_back(8'hFF >> (8 - k));
    exp_ok.push_back(ok);
    exp_len.push_back(got + 4);
    exp_class.push_back(expected_class(got + 4, ok));
    if (ok) begin
        exp_good++;
    end else begin
        exp_bad++;
    end

    drive_word('{data: 64'hD555_5555_5555_55FB, ctrl: 8'h01});
    for (int wi = 0; wi <= n / 8; wi++) begin
        w.ctrl = '0;
        for (int l = 0; l < LANES; l++) begin
            idx = 8 * wi + l;
            if (idx < n) begin
                w.data[8*l +: 8] = frame[idx];
            end else if (idx == n) begin
                w.data[8*l +: 8] = XGMII_TERM;
                w.ctrl[l] = 1'b1;
            end else begin
                w.data[8*l +: 8] = XGMII_IDLE;
                w.ctrl[l] = 1'b1;
            end
        end
        // error character in lane 0
        if (wi == err_word) begin
            w.data[7:0] = 8'hFE;
            w.ctrl[0] = 1'b1;
        end
        drive_word(w);
    end
endtask

`endif

//--- verification/tb_xgmii_rx.sv
`timescale 1ns/100ps

module tb_xgmii_rx
    import xgmii_rx_pkg::*;
();

    localparam int MAX_FRAME_LEN = 1518;
    localparam int WAIT_LIMIT    = 200;
    localparam xgmii_word_t IDLE_WORD = '{data: {8{XGMII_IDLE}}, ctrl: 8'hFF};

    typedef logic [7:0] byte_q_t[$];

    logic        clk;
    logic        inv_aresetn;
    xgmii_word_t xgmii;
    rx_stream_t  axis;
    rx_stat_t    stat;
    logic [31:0] good_frames;
    logic [31:0] bad_frames;

    // expected results
    logic [7:0]  exp_bytes[$];
    int          exp_nbytes[$];
    logic [7:0]  exp_keep[$];
    logic        exp_ok[$];
    int          exp_len[$];
    size_class_t exp_class[$];
    int          exp_good = 0;
    int          exp_bad = 0;

    // observed results
    logic [7:0]  rx_bytes[$];
    int          rx_nbytes[$];
    logic [7:0]  rx_keep[$];
    logic        rx_ok[$];
    int          rx_beats = 0;
    int          rx_cur = 0;
    int          st_len[$];
    size_class_t st_class[$];
    logic        st_ok[$];

    `include "tb_eth_model.svh"

    xgmii_rx_top #(
        .MAX_FRAME_LEN (MAX_FRAME_LEN)
    ) DUT (
        .clk           (clk),
        .inv_aresetn   (inv_aresetn),
        .xgmii_i       (xgmii),
        .axis_o        (axis),
        .stat_o        (stat),
        .good_frames_o (good_frames),
        .bad_frames_o  (bad_frames)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // ------------------------------
    // output capture on the falling edge
    // ------------------------------
    always @(negedge clk) begin
        if (axis.tvalid === 1'b1) begin
            rx_beats++;
            for (int l = 0; l < LANES; l++) begin
                if (axis.tkeep[l]) begin
                    rx_bytes.push_back(axis.tdata[8*l +: 8]);
                    rx_cur++;
                end
            end
            if (axis.tlast) begin
                rx_nbytes.push_back(rx_cur);
                rx_keep.push_back(axis.tkeep);
                rx_ok.push_back(axis.tuser);
                rx_cur = 0;
            end
        end
        if (stat.valid === 1'b1) begin
            st_len.push_back(int'(stat.len));
            st_class.push_back(stat.size);
            st_ok.push_back(stat.crc_ok);
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic wait_results();
        int cycles;
        cycles = 0;
        while (rx_nbytes.size() < exp_nbytes.size() && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (rx_nbytes.size() < exp_nbytes.size()) begin
            fail_run("timeout: the last beat (tlast) of a frame never arrived");
        end
        cycles = 0;
        while (st_len.size() < exp_len.size() && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (st_len.size() < exp_len.size()) begin
            fail_run("timeout: the frame statistic (stat valid) never arrived");
        end
    endtask

    task automatic check_results();
        int          n_exp;
        int          n_got;
        logic [7:0]  b_exp;
        logic [7:0]  b_got;
        logic [7:0]  k_got;
        logic        ok_exp;
        logic        ok_got;
        int          len_got;
        size_class_t cls_exp;
        size_class_t cls_got;
        wait_results();
        while (exp_nbytes.size() > 0) begin
            n_exp = exp_nbytes.pop_front();
            n_got = rx_nbytes.pop_front();
            assert (n_got == n_exp) else
                fail_run($sformatf("[ERROR] %0t: %0d payload bytes, expected %0d",
                    $time, n_got, n_exp));
            for (int i = 0; i < n_exp; i++) begin
                b_exp = exp_bytes.pop_front();
                b_got = rx_bytes.pop_front();
                assert (b_got == b_exp) else
                    fail_run($sformatf("[ERROR] %0t: byte %0d is %h, expected %h",
                        $time, i, b_got, b_exp));
            end
            k_got = rx_keep.pop_front();
            assert (k_got == exp_keep[0]) else
                fail_run($sformatf("[ERROR] %0t: last keep %h, expected %h",
                    $time, k_got, exp_keep[0]));
            void'(exp_keep.pop_front());
            ok_exp = exp_ok.pop_front();
            ok_got = rx_ok.pop_front();
            assert (ok_got == ok_exp) else
                fail_run($sformatf("[ERROR] %0t: tuser %b, expected %b", $time, ok_got, ok_exp));
            len_got = st_len.pop_front();
            assert (len_got == exp_len[0]) else
                fail_run($sformatf("[ERROR] %0t: stat len %0d, expected %0d",
                    $time, len_got, exp_len[0]));
            void'(exp_len.pop_front());
            cls_exp = exp_class.pop_front();
            cls_got = st_class.pop_front();
            assert (cls_got == cls_exp) else
                fail_run($sformatf("[ERROR] %0t: size class %0d, expected %0d",
                    $time, cls_got, cls_exp));
            ok_got = st_ok.pop_front();
            assert (ok_got == ok_exp) else
                fail_run($sformatf("[ERROR] %0t: stat crc_ok %b, expected %b",
                    $time, ok_got, ok_exp));
        end
        assert (rx_nbytes.size() == 0) else
            fail_run($sformatf("[ERROR] %0t: %0d unexpected extra frames",
                $time, rx_nbytes.size()));
        assert (st_len.size() == 0) else
            fail_run($sformatf("[ERROR] %0t: %0d unexpected extra frame statistics",
                $time, st_len.size()));
        assert (good_frames == exp_good) else
            fail_run($sformatf("[ERROR] %0t: good_frames %0d, expected %0d",
                $time, good_frames, exp_good));
        assert (bad_frames == exp_bad) else
            fail_run($sformatf("[ERROR] %0t: bad_frames %0d, expected %0d",
                $time, bad_frames, exp_bad));
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic single_good_frame();
        send_frame(random_payload(60), 1'b0, -1);
        send_idles(4);
        check_results();
    endtask

    // payloads 60 to 67 put T in every lane
    task automatic all_term_lanes();
        for (int len = 60; len <= 67; len++) begin
            send_frame(random_payload(len), 1'b0, -1);
            send_idles(2);
        end
        send_idles(2);
        check_results();
    endtask

    task automatic fcs_errors();
        send_frame(random_payload(40), 1'b1, -1);
        send_idles(3);
        send_frame(random_payload(100), 1'b1, -1);
        send_idles(4);
        check_results();
    endtask

    task automatic abort_and_lane4_start();
        int beats_before;
        send_frame(random_payload(60), 1'b0, 3);
        send_idles(4);
        check_results();
        beats_before = rx_beats;
        // start in lane 4 is not recovered
        drive_word('{data: 64'h5555_55FB_0707_0707, ctrl: 8'h1F});
        drive_word('{data: 64'hD555_5555_5555_5555, ctrl: 8'h00});
        drive_word('{data: {rand_bits(32), rand_bits(32)}, ctrl: 8'h00});
        drive_word('{data: {{7{XGMII_IDLE}}, XGMII_TERM}, ctrl: 8'hFF});
        send_idles(8);
        assert (rx_beats == beats_before) else
            fail_run($sformatf("[ERROR] %0t: lane-4 start produced %0d beats",
                $time, rx_beats - beats_before));
        assert (good_frames == exp_good && bad_frames == exp_bad) else
            fail_run($sformatf("[ERROR] %0t: counters moved on a lane-4 start", $time));
    endtask

    task automatic back_to_back_frames();
        int len;
        for (int f = 0; f < 8; f++) begin
            if (f == 0) begin
                len = 1600;
            end else if (f == 1) begin
                len = 46;
            end else begin
                len = 46 + int'(rand_bits(11) % 1555);
            end
            send_frame(random_payload(len), f == 4, -1);
        end
        send_idles(4);
        check_results();
    endtask

    initial begin
        inv_aresetn = 1'b1;
        xgmii = IDLE_WORD;
        repeat (5) @(posedge clk);
        #1;
        inv_aresetn = 1'b0;
        send_idles(4);
        single_good_frame();
        all_term_lanes();
        fcs_errors();
        abort_and_lane4_start();
        back_to_back_frames();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
+incdir+verification
hw/xgmii_rx_pkg.sv
hw/xgmii_frame_parser.sv
hw/xgmii_crc_check.sv
hw/rx_frame_stats.sv
hw/xgmii_rx_top.sv
verification/tb_xgmii_rx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the xgmii receive testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f \
    --top-module tb_xgmii_rx \
    -o tb_xgmii_rx \
    && ./obj_dir/tb_xgmii_rx \
    && echo "simulation run completed" \
    || { echo "simulation run failed"; exit 1; }
